//--- src.f
+incdir+tb
src/agen_pkg.sv
src/reg_size_select.sv
src/string_addr.sv
src/operand_select.sv
src/pipe_stage.sv
src/agen_top.sv
tb/agen_tb.sv

//--- src/agen_pkg.sv
// ####################
// agen package
// widths, enums and register bank types for the address generation stage
// ####################
package agen_pkg;

    localparam int GPR_W     = 32;
    localparam int SEG_W     = 16;
    localparam int OPND_W    = 64;
    localparam int IMM_W     = 48;
    localparam int PC_W      = 32;
    localparam int SEG_SHIFT = 16;

    typedef enum logic [2:0] {
        SRC_NONE  = 3'd0,
        SRC_REG   = 3'd1,
        SRC_SEG   = 3'd2,
        SRC_MMX   = 3'd3,
        SRC_MODRM = 3'd4,
        SRC_IMM   = 3'd5,
        SRC_MEM   = 3'd6,
        SRC_SYS   = 3'd7
    } opnd_src_e;

    // codes 0, 4, 6 and 7 select nothing
    typedef enum logic [2:0] {
        SZ_8  = 3'd1,
        SZ_16 = 3'd2,
        SZ_32 = 3'd3,
        SZ_64 = 3'd5
    } op_size_e;

    typedef enum logic [2:0] {ES, CS, SS, DS, FS, GS} seg_reg_e;

    typedef enum logic [2:0] {EAX, ECX, EDX, EBX, ESP, EBP, ESI, EDI} gpr_e;

    typedef logic [7:0][GPR_W-1:0]  gpr_bank_t;
    typedef logic [5:0][SEG_W-1:0]  seg_bank_t;
    typedef logic [7:0][OPND_W-1:0] mmx_bank_t;
    typedef logic [7:0][OPND_W-1:0] opnd_bank_t;

    // size, d flags, operands, reg numbers, is_address flags, imm,
    // alu op, flag selectors, stack op, pc, branch taken
    localparam int PAYLOAD_W = $bits(op_size_e) + 2 + 2 * OPND_W + 2 * 3 + 2 + IMM_W
                             + 4 + 2 * 3 + 2 + PC_W + 1;

    // segment lookup, codes past GS read as zero
    function automatic logic [SEG_W-1:0] seg_value(seg_bank_t seg, logic [2:0] num);
        logic [SEG_W-1:0] val;
        val = '0;
        if (num <= GS) begin
            val = seg[num];
        end
        return val;
    endfunction

endpackage

//--- src/agen_top.sv
// ####################
// agen_top
// address generation stage: operand select, string addresses,
// one pipeline register toward the memory stage
// ####################
`timescale 1ns/1ps

module agen_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,

    // from register stage
    input  logic                         r_valid,
    output logic                         r_ready,
    input  agen_pkg::op_size_e           r_size,
    input  logic                         r_set_d_flag,
    input  logic                         r_clear_d_flag,
    input  agen_pkg::opnd_src_e          r_op0,
    input  agen_pkg::opnd_src_e          r_op1,
    input  logic [2:0]                   r_op0_reg,
    input  logic [2:0]                   r_op1_reg,
    input  logic [agen_pkg::IMM_W-1:0]   r_imm,
    input  logic [3:0]                   r_alu_op,
    input  logic [2:0]                   r_flag_0,
    input  logic [2:0]                   r_flag_1,
    input  logic [1:0]                   r_stack_op,
    input  agen_pkg::seg_reg_e           r_seg_override,
    input  logic                         r_seg_override_valid,
    input  agen_pkg::gpr_bank_t          r_gpr,
    input  agen_pkg::seg_bank_t          r_seg,
    input  agen_pkg::mmx_bank_t          r_mm,
    input  logic [agen_pkg::PC_W-1:0]    r_pc,
    input  logic                         r_branch_taken,

    // to memory stage
    output logic                         a_valid,
    input  logic                         a_ready,
    output agen_pkg::op_size_e           a_size,
    output logic                         a_set_d_flag,
    output logic                         a_clear_d_flag,
    output logic [agen_pkg::OPND_W-1:0]  a_op0,
    output logic [agen_pkg::OPND_W-1:0]  a_op1,
    output logic [2:0]                   a_op0_reg,
    output logic [2:0]                   a_op1_reg,
    output logic                         a_op0_is_address,
    output logic                         a_op1_is_address,
    output logic [agen_pkg::IMM_W-1:0]   a_imm,
    output logic [3:0]                   a_alu_op,
    output logic [2:0]                   a_flag_0,
    output logic [2:0]                   a_flag_1,
    output logic [1:0]                   a_stack_op,
    output logic [agen_pkg::PC_W-1:0]    a_pc,
    output logic                         a_branch_taken,
    output logic                         a_to_sys_controller
);
    import agen_pkg::*;

    opnd_bank_t           views;
    logic [GPR_W-1:0]     dst_addr;
    logic [GPR_W-1:0]     src_addr;
    logic [OPND_W-1:0]    op0_val;
    logic [OPND_W-1:0]    op1_val;
    logic                 op0_is_addr;
    logic                 op1_is_addr;
    logic [PAYLOAD_W-1:0] pipe_in;
    logic [PAYLOAD_W-1:0] pipe_out;
    logic [2:0]           size_bits;

    reg_size_select u_size_sel (
        .size  (r_size),
        .gpr   (r_gpr),
        .mmx   (r_mm),
        .views (views)
    );

    string_addr u_str_addr (
        .gpr                (r_gpr),
        .seg                (r_seg),
        .seg_override       (r_seg_override),
        .seg_override_valid (r_seg_override_valid),
        .dst_addr           (dst_addr),
        .src_addr           (src_addr)
    );

    // op0 addresses the es:edi destination
    operand_select u_op0_sel (
        .src        (r_op0),
        .reg_num    (r_op0_reg),
        .views      (views),
        .seg        (r_seg),
        .mmx        (r_mm),
        .imm        (r_imm),
        .mem_addr   (dst_addr),
        .opnd       (op0_val),
        .is_address (op0_is_addr)
    );

    // op1 addresses the string source
    operand_select u_op1_sel (
        .src        (r_op1),
        .reg_num    (r_op1_reg),
        .views      (views),
        .seg        (r_seg),
        .mmx        (r_mm),
        .imm        (r_imm),
        .mem_addr   (src_addr),
        .opnd       (op1_val),
        .is_address (op1_is_addr)
    );

    assign pipe_in = {
        r_size, r_set_d_flag, r_clear_d_flag,
        op0_val, op1_val,
        r_op0_reg, r_op1_reg,
        op0_is_addr, op1_is_addr,
        r_imm, r_alu_op,
        r_flag_0, r_flag_1,
        r_stack_op, r_pc, r_branch_taken
    };

    pipe_stage #(
        .WIDTH (PAYLOAD_W)
    ) u_stage (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (pipe_in),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (pipe_out)
    );

    assign {
        size_bits, a_set_d_flag, a_clear_d_flag,
        a_op0, a_op1,
        a_op0_reg, a_op1_reg,
        a_op0_is_address, a_op1_is_address,
        a_imm, a_alu_op,
        a_flag_0, a_flag_1,
        a_stack_op, a_pc, a_branch_taken
    } = pipe_out;

    assign a_size = op_size_e'(size_bits);

    // system op, seen straight from decode without waiting for the stage
    assign a_to_sys_controller = (r_op0 == SRC_SYS);

endmodule

//--- src/operand_select.sv
// ####################
// operand_select
// source mux for one operand, flags memory addresses
// ####################
`timescale 1ns/1ps

module operand_select (
    input  agen_pkg::opnd_src_e          src,
    input  logic [2:0]                   reg_num,
    input  agen_pkg::opnd_bank_t         views,
    input  agen_pkg::seg_bank_t          seg,
    input  agen_pkg::mmx_bank_t          mmx,
    input  logic [agen_pkg::IMM_W-1:0]   imm,
    input  logic [agen_pkg::GPR_W-1:0]   mem_addr,
    output logic [agen_pkg::OPND_W-1:0]  opnd,
    output logic                         is_address
);
    import agen_pkg::*;

    logic [SEG_W-1:0] seg_sel;

    // segment codes 6 and 7 read as zero
    assign seg_sel = seg_value(seg, reg_num);

    always_comb begin
        case (src)
            SRC_REG: begin
                // already masked to the operand size
                opnd = views[reg_num];
            end
            SRC_SEG: begin
                opnd = OPND_W'(seg_sel);
            end
            SRC_MMX: begin
                // raw mmx register regardless of size
                opnd = mmx[reg_num];
            end
            SRC_IMM: begin
                opnd = OPND_W'(imm);
            end
            SRC_MEM: begin
                opnd = OPND_W'(mem_addr);
            end
            default: begin
                // none, sys, and the unused mod r/m code
                opnd = '0;
            end
        endcase
    end

    // only string memory sources carry an address to the next stage
    assign is_address = (src == SRC_MEM);

    // mod r/m addressing is not supported by this stage
    always_comb begin
        assert final (src !== SRC_MODRM)
        else $error("operand_select: reserved source SRC_MODRM selected");
    end

endmodule

//--- src/pipe_stage.sv
// ####################
// pipe_stage
// one-entry valid/ready register with flush
// ####################
`timescale 1ns/1ps

module pipe_stage #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    logic load;

    // empty, or the held item leaves on this edge
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

    // held item stays put while the consumer stalls
    property p_stall_hold;
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_data));
    endproperty

    a_stall_hold: assert property (p_stall_hold)
    else $error("pipe_stage: payload changed during stall");

    a_reset_empty: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("pipe_stage: valid set after reset");

endmodule

//--- src/reg_size_select.sv
// ####################
// reg_size_select
// size-masked views of the eight general / mmx registers
// ####################
`timescale 1ns/1ps

module reg_size_select (
    input  agen_pkg::op_size_e   size,
    input  agen_pkg::gpr_bank_t  gpr,
    input  agen_pkg::mmx_bank_t  mmx,
    output agen_pkg::opnd_bank_t views
);
    import agen_pkg::*;

    // byte registers: al cl dl bl then ah ch dh bh
    logic [7:0][7:0] byte_view;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byte_view[i]     = gpr[i][7:0];
            // high byte of the same four registers
            byte_view[i + 4] = gpr[i][15:8];
        end
    end

    // one size decode shared by both operands
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (size)
                SZ_8: begin
                    views[i] = OPND_W'(byte_view[i]);
                end
                SZ_16: begin
                    views[i] = OPND_W'(gpr[i][15:0]);
                end
                SZ_32: begin
                    views[i] = OPND_W'(gpr[i]);
                end
                SZ_64: begin
                    // 64-bit operands only exist in the mmx file
                    views[i] = mmx[i];
                end
                default: begin
                    views[i] = '0;
                end
            endcase
        end
    end

endmodule

//--- src/string_addr.sv
// ####################
// string_addr
// es:edi and ds/override:esi linear addresses for string ops
// ####################
`timescale 1ns/1ps

module string_addr (
    input  agen_pkg::gpr_bank_t          gpr,
    input  agen_pkg::seg_bank_t          seg,
    input  agen_pkg::seg_reg_e           seg_override,
    input  logic                         seg_override_valid,
    output logic [agen_pkg::GPR_W-1:0]   dst_addr,
    output logic [agen_pkg::GPR_W-1:0]   src_addr
);
    import agen_pkg::*;

    logic [SEG_W-1:0] src_seg;
    logic [GPR_W-1:0] dst_base;
    logic [GPR_W-1:0] src_base;

    // destination segment is always es
    assign dst_base = GPR_W'(seg[ES]) << SEG_SHIFT;

    // source defaults to ds, override may pick any segment
    assign src_seg  = seg_override_valid ? seg_value(seg, seg_override) : seg[DS];
    assign src_base = GPR_W'(src_seg) << SEG_SHIFT;

    // carry out of bit 31 is dropped
    assign dst_addr = dst_base + gpr[EDI];
    assign src_addr = src_base + gpr[ESI];

    // decode should never hand over an override code past gs
    always_comb begin
        assert final ((seg_override_valid !== 1'b1) || $isunknown(seg_override)
                      || (seg_override <= GS))
        else $error("string_addr: override segment code %0d out of range",
                    seg_override);
    end

endmodule

//--- tb/agen_ref.svh
// ####################
// agen reference model
// expected payload fields worked out from the stage rules
// ####################
`ifndef AGEN_REF_SVH
`define AGEN_REF_SVH

typedef struct packed {
    op_size_e    size;
    logic        set_d;
    logic        clear_d;
    logic [63:0] op0;
    logic [63:0] op1;
    logic [2:0]  op0_reg;
    logic [2:0]  op1_reg;
    logic        op0_addr;
    logic        op1_addr;
    logic [47:0] imm;
    logic [3:0]  alu_op;
    logic [2:0]  flag_0;
    logic [2:0]  flag_1;
    logic [1:0]  stack_op;
    logic [31:0] pc;
    logic        branch;
} item_t;

// general register seen at the operand size
function automatic logic [63:0] sized_view(op_size_e size, gpr_bank_t gpr,
                                           mmx_bank_t mm, logic [2:0] num);
    logic [63:0] val;
    val = '0;
    case (size)
        SZ_8: begin
            // 4..7 are ah, ch, dh, bh
            if (num < 3'd4) begin
                val = 64'(gpr[num][7:0]);
            end else begin
                val = 64'(gpr[num[1:0]][15:8]);
            end
        end
        SZ_16: val = 64'(gpr[num][15:0]);
        SZ_32: val = 64'(gpr[num]);
        SZ_64: val = mm[num];
        default: val = '0;
    endcase
    return val;
endfunction

// only es..gs exist
function automatic logic [15:0] seg_or_zero(seg_bank_t seg, logic [2:0] num);
    logic [15:0] val;
    val = '0;
    if (num < 3'd6) begin
        val = seg[num];
    end
    return val;
endfunction

// segment times 65536 plus offset, wraps at 32 bits
function automatic logic [31:0] linear_addr(logic [15:0] seg_val, logic [31:0] offset);
    return {seg_val, 16'h0000} + offset;
endfunction

function automatic logic [63:0] expected_operand(opnd_src_e src, logic [2:0] num,
                                                 op_size_e size, gpr_bank_t gpr,
                                                 seg_bank_t seg, mmx_bank_t mm,
                                                 logic [47:0] imm, logic [31:0] addr);
    case (src)
        SRC_REG: return sized_view(size, gpr, mm, num);
        SRC_SEG: return 64'(seg_or_zero(seg, num));
        SRC_MMX: return mm[num];
        SRC_IMM: return 64'(imm);
        SRC_MEM: return 64'(addr);
        default: return '0;
    endcase
endfunction

`endif

//--- tb/agen_tb.sv
// ####################
// agen_tb
// random traffic through agen_top with a queue scoreboard
// ####################
`timescale 1ns/1ps

module agen_tb;
    import agen_pkg::*;

    `include "agen_ref.svh"

    localparam int N_ITEMS        = 400;
    localparam int TIMEOUT_CYCLES = 20 * N_ITEMS;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                r_valid;
    logic                r_ready;
    op_size_e            r_size;
    logic                r_set_d_flag;
    logic                r_clear_d_flag;
    opnd_src_e           r_op0;
    opnd_src_e           r_op1;
    logic [2:0]          r_op0_reg;
    logic [2:0]          r_op1_reg;
    logic [IMM_W-1:0]    r_imm;
    logic [3:0]          r_alu_op;
    logic [2:0]          r_flag_0;
    logic [2:0]          r_flag_1;
    logic [1:0]          r_stack_op;
    seg_reg_e            r_seg_override;
    logic                r_seg_override_valid;
    gpr_bank_t           r_gpr;
    seg_bank_t           r_seg;
    mmx_bank_t           r_mm;
    logic [PC_W-1:0]     r_pc;
    logic                r_branch_taken;
    logic                a_valid;
    logic                a_ready;
    op_size_e            a_size;
    logic                a_set_d_flag;
    logic                a_clear_d_flag;
    logic [OPND_W-1:0]   a_op0;
    logic [OPND_W-1:0]   a_op1;
    logic [2:0]          a_op0_reg;
    logic [2:0]          a_op1_reg;
    logic                a_op0_is_address;
    logic                a_op1_is_address;
    logic [IMM_W-1:0]    a_imm;
    logic [3:0]          a_alu_op;
    logic [2:0]          a_flag_0;
    logic [2:0]          a_flag_1;
    logic [1:0]          a_stack_op;
    logic [PC_W-1:0]     a_pc;
    logic                a_branch_taken;
    logic                a_to_sys_controller;

    item_t exp_q[$];
    int    pushed;
    int    cycles;

    agen_top DUT (.*);

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input op_size_e got, input op_size_e exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // any source except the reserved mod r/m code
    function automatic opnd_src_e random_source();
        logic [2:0] code;
        code = 3'($urandom_range(0, 6));
        if (code >= 3'd4) begin
            code = code + 3'd1;
        end
        return opnd_src_e'(code);
    endfunction

    function automatic item_t expected_item();
        item_t       it;
        logic [15:0] src_seg;
        logic [31:0] dst;
        logic [31:0] src;
        src_seg = r_seg_override_valid ? seg_or_zero(r_seg, r_seg_override) : r_seg[DS];
        dst = linear_addr(r_seg[ES], r_gpr[EDI]);
        src = linear_addr(src_seg, r_gpr[ESI]);
        it.size     = r_size;
        it.set_d    = r_set_d_flag;
        it.clear_d  = r_clear_d_flag;
        it.op0      = expected_operand(r_op0, r_op0_reg, r_size, r_gpr, r_seg, r_mm,
                                       r_imm, dst);
        it.op1      = expected_operand(r_op1, r_op1_reg, r_size, r_gpr, r_seg, r_mm,
                                       r_imm, src);
        it.op0_reg  = r_op0_reg;
        it.op1_reg  = r_op1_reg;
        it.op0_addr = (r_op0 == SRC_MEM);
        it.op1_addr = (r_op1 == SRC_MEM);
        it.imm      = r_imm;
        it.alu_op   = r_alu_op;
        it.flag_0   = r_flag_0;
        it.flag_1   = r_flag_1;
        it.stack_op = r_stack_op;
        it.pc       = r_pc;
        it.branch   = r_branch_taken;
        return it;
    endfunction

    task automatic compare_item(input item_t exp);
        check_size("a_size", a_size, exp.size);
        check_bit("a_set_d_flag", a_set_d_flag, exp.set_d);
        check_bit("a_clear_d_flag", a_clear_d_flag, exp.clear_d);
        check_value("a_op0", a_op0, exp.op0);
        check_value("a_op1", a_op1, exp.op1);
        check_value("a_op0_reg", 64'(a_op0_reg), 64'(exp.op0_reg));
        check_value("a_op1_reg", 64'(a_op1_reg), 64'(exp.op1_reg));
        check_bit("a_op0_is_address", a_op0_is_address, exp.op0_addr);
        check_bit("a_op1_is_address", a_op1_is_address, exp.op1_addr);
        check_value("a_imm", 64'(a_imm), 64'(exp.imm));
        check_value("a_alu_op", 64'(a_alu_op), 64'(exp.alu_op));
        check_value("a_flag_0", 64'(a_flag_0), 64'(exp.flag_0));
        check_value("a_flag_1", 64'(a_flag_1), 64'(exp.flag_1));
        check_value("a_stack_op", 64'(a_stack_op), 64'(exp.stack_op));
        check_value("a_pc", 64'(a_pc), 64'(exp.pc));
        check_bit("a_branch_taken", a_branch_taken, exp.branch);
    endtask

    task automatic drive_random();
        for (int i = 0; i < 8; i++) begin
            r_gpr[i] = $urandom();
            r_mm[i]  = {$urandom(), $urandom()};
        end
        for (int i = 0; i < 6; i++) begin
            r_seg[i] = 16'($urandom());
        end
        r_size               = op_size_e'(3'($urandom_range(0, 7)));
        r_op0                = random_source();
        r_op1                = random_source();
        r_op0_reg            = 3'($urandom());
        r_op1_reg            = 3'($urandom());
        r_imm                = {16'($urandom()), 32'($urandom())};
        r_set_d_flag         = 1'($urandom());
        r_clear_d_flag       = 1'($urandom());
        r_alu_op             = 4'($urandom());
        r_flag_0             = 3'($urandom());
        r_flag_1             = 3'($urandom());
        r_stack_op           = 2'($urandom());
        r_seg_override       = seg_reg_e'(3'($urandom_range(0, 5)));
        r_seg_override_valid = 1'($urandom());
        r_pc                 = $urandom();
        r_branch_taken       = 1'($urandom());
        r_valid              = ($urandom_range(0, 3) != 0);
        a_ready              = ($urandom_range(0, 3) != 0);
        flush                = ($urandom_range(0, 99) == 0);
    endtask

    // values seen at the falling edge are the ones the next rising edge uses
    always @(negedge clk) begin
        item_t exp;
        logic  stage_full;
        if (rst) begin
            exp_q.delete();
        end else begin
            // one-entry stage, the queue holds only the item in the register
            stage_full = (exp_q.size() != 0);
            check_bit("a_valid", a_valid, stage_full);
            check_bit("r_ready", r_ready, !stage_full || a_ready);
            check_bit("a_to_sys_controller", a_to_sys_controller, r_op0 == SRC_SYS);
            if (flush) begin
                exp_q.delete();
            end else begin
                if (a_valid && a_ready) begin
                    if (exp_q.size() == 0) begin
                        fail_run("output transfer seen with no item expected");
                    end
                    exp = exp_q.pop_front();
                    compare_item(exp);
                end
                if (r_valid && r_ready) begin
                    exp_q.push_back(expected_item());
                    pushed++;
                end
            end
        end
    end

    // about 20 cycles per item
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h22fc4762));
        clk    = 1'b0;
        rst    = 1'b1;
        pushed = 0;
        cycles = 0;
        r_gpr  = '0;
        r_seg  = '0;
        r_mm   = '0;
        r_size = SZ_8;
        r_op0  = SRC_NONE;
        r_op1  = SRC_NONE;
        r_op0_reg = '0;
        r_op1_reg = '0;
        r_imm  = '0;
        r_set_d_flag   = 1'b0;
        r_clear_d_flag = 1'b0;
        r_alu_op   = '0;
        r_flag_0   = '0;
        r_flag_1   = '0;
        r_stack_op = '0;
        r_seg_override       = ES;
        r_seg_override_valid = 1'b0;
        r_pc           = '0;
        r_branch_taken = 1'b0;
        r_valid = 1'b0;
        a_ready = 1'b0;
        flush   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        while (pushed < N_ITEMS) begin
            drive_random();
            @(posedge clk);
            #1;
        end
        // drain with the consumer always ready
        r_valid = 1'b0;
        a_ready = 1'b1;
        flush   = 1'b0;
        while (a_valid) begin
            @(posedge clk);
            #1;
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d accepted items never came out", exp_q.size()));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
